//--- wb_trace.txt
# word pc opa opb gap full kind exp1 exp2 (hex, gap and full in decimal)
# reg: rd data, mem: addr data, redir: pc, exc: code, none/halt/squash: unused
02000000 00000100 00000005 00000007 0 0 reg 1 0000000c
14000000 00000104 0000000a 00000003 0 0 reg 2 00000007
26000000 00000108 0000f0f0 0000ff00 1 0 reg 3 0000f000
38000000 0000010c 000000f0 0000000f 0 0 reg 4 000000ff
4a000000 00000110 000000ff 0000000f 0 0 reg 5 000000f0
5c000000 00000114 00000001 00000024 2 0 reg 6 00000010
60000010 00000118 00001000 deadbeef 0 3 mem 00001010 deadbeef
6000fffc 0000011c 00002000 12345678 3 5 mem 00001ffc 12345678
70000040 00000200 00000003 00000003 0 0 redir 00000240 0
0e000000 00000204 00000001 00000001 0 0 squash 0 0
81000020 00000300 00000005 00000005 2 0 redir 00000304 0
14000000 00000304 00000009 00000001 0 0 squash 0 0
71000008 00000400 00000009 00000009 1 0 none 0 0
02000000 00000408 00000002 00000003 0 0 reg 1 00000005
02800000 0000040c 7fffffff 00000001 0 0 exc 1 0
04800000 00000410 00000001 00000002 0 0 reg 2 00000003
a2000000 00000414 00000000 00000000 0 0 exc 2 0
f0000000 00000418 00000000 00000000 3 0 exc 2 0
56000000 0000041c 00000003 ffffffe1 0 0 reg 3 00000006
80000010 00000500 00000004 00000004 0 0 none 0 0
60000000 00000504 00003000 a5a5a5a5 0 2 mem 00003000 a5a5a5a5
90000000 00000508 00000000 00000000 0 0 halt 0 0
02000000 0000050c 00000011 00000022 0 0 squash 0 0
60000000 00000510 00000000 00000000 0 0 squash 0 0
14000000 00000514 00000000 00000000 0 0 squash 0 0

//--- sim.f
+incdir+.
wb_pkg.sv
pipe_if.sv
pipe_reg.sv
uop_decode.sv
uop_execute.sv
writeback.sv
core_wb_top.sv
tb_clock.sv
tb_core_wb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_core_wb
FILELIST  := sim.f
FLAGS     := --timing --assert --timescale 1ns/1ns
OBJ_DIR   := obj_dir
PASS_MSG  := Testbench passed

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# fails unless the pass line shows up in the simulation output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_core_wb.sv
`timescale 1ns/1ns
`default_nettype none
`include "wb_defs.svh"

module tb_core_wb;

    import wb_pkg::*;

    localparam int MAX_LINES       = 64;
    localparam int CYCLES_PER_LINE = 40;
    localparam logic [31:0] SEED   = 32'h2baaeaa7;

    typedef struct {
        string               kind;   // reg mem redir exc halt none squash
        logic [`WB_XLEN-1:0] e1;
        logic [`WB_XLEN-1:0] e2;
    } expect_t;

    logic                clk, rst, in_valid, in_ready, wbq_full;
    logic                reg_we, mem_we, resteer, exc_valid, halted;
    logic [`WB_XLEN-1:0] in_word, in_pc, in_opa, in_opb;
    logic [`WB_XLEN-1:0] reg_data, mem_addr, mem_data, resteer_pc;
    logic [`WB_RIDX-1:0] reg_addr;
    logic [3:0]          exc_code;

    logic [`WB_XLEN-1:0] t_word [MAX_LINES];
    logic [`WB_XLEN-1:0] t_pc [MAX_LINES];
    logic [`WB_XLEN-1:0] t_opa [MAX_LINES];
    logic [`WB_XLEN-1:0] t_opb [MAX_LINES];
    int                  t_gap [MAX_LINES];
    int                  t_full [MAX_LINES];
    expect_t             t_exp [MAX_LINES];

    int      n_lines, cur, full_len, full_arm, limit_cycles, err_value, err_proto;
    bit      halt_seen;
    expect_t pending[$];   // accepted, not yet retired

    tb_clock #(.PERIOD(20), .RST_CYCLES(10)) tb_clock_i (.clk(clk), .rst(rst));

    core_wb_top core_wb_top_i (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_word(in_word), .in_pc(in_pc),
        .in_opa(in_opa), .in_opb(in_opb), .in_ready(in_ready),
        .wbq_full(wbq_full),
        .reg_we(reg_we), .reg_addr(reg_addr), .reg_data(reg_data),
        .mem_we(mem_we), .mem_addr(mem_addr), .mem_data(mem_data),
        .resteer(resteer), .resteer_pc(resteer_pc),
        .exc_valid(exc_valid), .exc_code(exc_code), .halted(halted)
    );

    task automatic protocol_error(input string msg);
        err_proto++;
        $display("%0t ns: %s", $time, msg);
    endtask

    task automatic check_reg(input reg_wr_t got, input reg_wr_t exp);
        if (got !== exp) begin
            err_value++;
            $display("[ERROR] %0t ns: reg write x%0d=%h, expected x%0d=%h",
                     $time, got.addr, got.data, exp.addr, exp.data);
        end
    endtask

    task automatic check_mem(input mem_wr_t got, input mem_wr_t exp);
        if (got !== exp) begin
            err_value++;
            $display("[ERROR] %0t ns: store [%h]=%h, expected [%h]=%h",
                     $time, got.addr, got.data, exp.addr, exp.data);
        end
    endtask

    task automatic check_redirect(input logic [`WB_XLEN-1:0] got, input logic [`WB_XLEN-1:0] exp);
        if (got !== exp) begin
            err_value++;
            $display("[ERROR] %0t ns: resteer to %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_exc(input exc_e got, input exc_e exp);
        if (got !== exp) begin
            err_value++;
            $display("[ERROR] %0t ns: exception %h (%s), expected %s",
                     $time, got, got.name(), exp.name());
        end
    endtask

    // oldest entry, skipping branches that retire without any output
    task automatic pop_expect(input string kind, output expect_t e, output bit ok);
        ok = 1'b0;
        while (pending.size() != 0 && pending[0].kind == "none") begin
            void'(pending.pop_front());
        end
        if (pending.size() == 0) begin
            protocol_error($sformatf("%s commit with no instruction outstanding", kind));
        end else begin
            e = pending.pop_front();
            if (e.kind != kind) begin
                protocol_error($sformatf("%s commit where the trace expects %s", kind, e.kind));
            end else begin
                ok = 1'b1;
            end
        end
    endtask

    task automatic drop_squashed();
        expect_t e;
        while (pending.size() != 0) begin
            e = pending.pop_front();
            if (e.kind != "squash") begin
                protocol_error($sformatf("a %s instruction was squashed", e.kind));
            end
        end
    endtask

    task automatic watch_commits();
        expect_t e;
        bit      ok;
        reg_wr_t rg;
        reg_wr_t rx;
        mem_wr_t mg;
        mem_wr_t mx;
        if (in_valid && in_ready) begin
            pending.push_back(t_exp[cur]);
        end
        if ($countones({reg_we, mem_we, resteer, exc_valid}) > 1) begin
            protocol_error("more than one commit in one cycle");
        end
        if (mem_we && wbq_full) begin
            protocol_error("store written while the queue was full");
        end
        if (reg_we) begin
            pop_expect("reg", e, ok);
            rg.addr = reg_addr;
            rg.data = reg_data;
            rx.addr = e.e1[`WB_RIDX-1:0];
            rx.data = e.e2;
            if (ok) check_reg(rg, rx);
        end
        if (mem_we) begin
            pop_expect("mem", e, ok);
            mg.addr = mem_addr;
            mg.data = mem_data;
            mx.addr = e.e1;
            mx.data = e.e2;
            if (ok) check_mem(mg, mx);
        end
        if (resteer) begin
            pop_expect("redir", e, ok);
            if (ok) check_redirect(resteer_pc, e.e1);
            drop_squashed();   // everything younger is gone
        end
        if (exc_valid) begin
            pop_expect("exc", e, ok);
            if (ok) check_exc(exc_e'(exc_code), exc_e'(e.e1[3:0]));
        end
        if (halted && !halt_seen) begin
            halt_seen = 1'b1;
            pop_expect("halt", e, ok);
            drop_squashed();
        end
        if (halted && in_ready) begin
            protocol_error("in_ready high after halt");
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          n;
        int          gap;
        int          full;
        string       line;
        string       kind;
        logic [31:0] w, pc, a, b, e1, e2;
        n_lines = 0;
        fd = $fopen("wb_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open wb_trace.txt");
        end else begin
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                if ($fgets(line, fd) == 0) break;
                if (line.len() < 2 || line.getc(0) == "#") continue;
                n = $sscanf(line, "%h %h %h %h %d %d %s %h %h",
                            w, pc, a, b, gap, full, kind, e1, e2);
                if (n != 9) begin
                    protocol_error($sformatf("malformed trace line: %s", line));
                    continue;
                end
                t_word[n_lines]     = w;
                t_pc[n_lines]       = pc;
                t_opa[n_lines]      = a;
                t_opb[n_lines]      = b;
                t_gap[n_lines]      = gap;
                t_full[n_lines]     = full;
                t_exp[n_lines].kind = kind;
                t_exp[n_lines].e1   = e1;
                t_exp[n_lines].e2   = e2;
                n_lines++;
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_line(input int i);
        repeat (t_gap[i]) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
        @(posedge clk);
        cur = i;
        in_valid <= 1'b1;
        in_word  <= t_word[i];
        in_pc    <= t_pc[i];
        in_opa   <= t_opa[i];
        in_opb   <= t_opb[i];
        @(negedge clk);
        while (!in_ready && !halted) @(negedge clk);
        if (in_ready && !halted && t_full[i] > 0) begin
            full_len = t_full[i];   // queue goes full when this one reaches writeback
            full_arm++;
        end
    endtask

    // wbq_full from the trace counts plus random single-cycle pulses
    initial begin
        int seen_arm;
        int left;
        void'($urandom(SEED));
        seen_arm = 0;
        left     = 0;
        wbq_full = 1'b0;
        forever begin
            @(posedge clk);
            if (rst) begin
                wbq_full <= 1'b0;
            end else if (full_arm != seen_arm) begin
                seen_arm = full_arm;
                left     = full_len;
                wbq_full <= ($urandom % 8) == 0;
            end else if (left > 0) begin
                left--;
                wbq_full <= 1'b1;
            end else begin
                wbq_full <= ($urandom % 8) == 0;
            end
        end
    end

    always @(negedge clk) begin
        if (rst) begin
            if ({reg_we, mem_we, resteer, exc_valid, halted} !== 5'b0) begin
                protocol_error("commit outputs not low during reset");
            end
        end else begin
            watch_commits();
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", limit_cycles);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        in_valid     = 1'b0;
        in_word      = '0;
        in_pc        = '0;
        in_opa       = '0;
        in_opb       = '0;
        full_len     = 0;
        full_arm     = 0;
        cur          = 0;
        err_value    = 0;
        err_proto    = 0;
        halt_seen    = 1'b0;
        limit_cycles = 0;
        load_trace();
        if (n_lines == 0) begin
            $display("no usable lines in the trace");
            $display("Testbench failed");
            $finish;
        end else begin
            limit_cycles = n_lines * CYCLES_PER_LINE;
            for (int i = 0; i < n_lines; i++) begin
                limit_cycles += t_gap[i] + t_full[i];
            end
            while (rst !== 1'b0) @(posedge clk);
            for (int i = 0; i < n_lines && !halted; i++) begin
                drive_line(i);
            end
            @(posedge clk);
            in_valid <= 1'b0;
            while (pending.size() != 0 && !halt_seen) @(negedge clk);
            repeat (8) @(negedge clk);   // catch late or extra commits
            $display("errors: %0d value mismatches, %0d protocol errors", err_value, err_proto);
            if (err_value == 0 && err_proto == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- core_wb_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "wb_defs.svh"

module core_wb_top (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                in_valid,
    input  wire logic [`WB_XLEN-1:0] in_word,
    input  wire logic [`WB_XLEN-1:0] in_pc,
    input  wire logic [`WB_XLEN-1:0] in_opa,
    input  wire logic [`WB_XLEN-1:0] in_opb,
    output logic                     in_ready,
    input  wire logic                wbq_full,
    output logic                     reg_we,
    output logic [`WB_RIDX-1:0]      reg_addr,
    output logic [`WB_XLEN-1:0]      reg_data,
    output logic                     mem_we,
    output logic [`WB_XLEN-1:0]      mem_addr,
    output logic [`WB_XLEN-1:0]      mem_data,
    output logic                     resteer,
    output logic [`WB_XLEN-1:0]      resteer_pc,
    output logic                     exc_valid,
    output logic [3:0]               exc_code,
    output logic                     halted
);

    import wb_pkg::*;

    logic    stall;
    logic    flush;
    reg_wr_t reg_wr;
    mem_wr_t mem_wr;

    pipe_if #(.payload_t(dec_t)) d_link ();   // decode -> D/X
    pipe_if #(.payload_t(dec_t)) x_link ();   // D/X -> execute
    pipe_if #(.payload_t(exe_t)) e_link ();   // execute -> X/W
    pipe_if #(.payload_t(exe_t)) w_link ();   // X/W -> writeback

    assign d_link.stall = stall;
    assign d_link.flush = flush;
    assign x_link.stall = stall;
    assign x_link.flush = flush;
    assign e_link.stall = stall;
    assign e_link.flush = flush;
    assign w_link.stall = stall;
    assign w_link.flush = flush;

    assign in_ready = !(stall || flush);

    uop_decode uop_decode_i (
        .valid(in_valid), .word(in_word), .pc(in_pc), .opa(in_opa), .opb(in_opb),
        .d(d_link.src)
    );

    pipe_reg #(.payload_t(dec_t)) dx_reg_i (
        .clk(clk), .rst(rst), .up(d_link.dst), .down(x_link.src)
    );

    uop_execute uop_execute_i (.x(x_link.dst), .e(e_link.src));

    pipe_reg #(.payload_t(exe_t)) xw_reg_i (
        .clk(clk), .rst(rst), .up(e_link.dst), .down(w_link.src)
    );

    writeback writeback_i (
        .clk(clk), .rst(rst), .wbq_full(wbq_full), .w(w_link.dst),
        .stall(stall), .flush(flush),
        .reg_we(reg_we), .reg_wr(reg_wr), .mem_we(mem_we), .mem_wr(mem_wr),
        .resteer(resteer), .resteer_pc(resteer_pc),
        .exc_valid(exc_valid), .exc_code(exc_code), .halted(halted)
    );

    assign reg_addr = reg_wr.addr;
    assign reg_data = reg_wr.data;
    assign mem_addr = mem_wr.addr;
    assign mem_data = mem_wr.data;

endmodule

`default_nettype wire

//--- writeback.sv
`timescale 1ns/1ns
`default_nettype none
`include "wb_defs.svh"

module writeback (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           wbq_full,
    pipe_if.dst                 w,
    output logic                stall,
    output logic                flush,
    output logic                reg_we,
    output wb_pkg::reg_wr_t     reg_wr,
    output logic                mem_we,
    output wb_pkg::mem_wr_t     mem_wr,
    output logic                resteer,
    output logic [`WB_XLEN-1:0] resteer_pc,
    output logic                exc_valid,
    output wb_pkg::exc_e        exc_code,
    output logic                halted
);

    import wb_pkg::*;

    exe_t wp;
    logic commit;        // item retires this cycle
    logic halt_commit;

    assign wp = w.payload;

    // store can't drain into a full queue
    assign stall = w.valid && (wp.kind == K_STORE) && wbq_full && !halted;

    assign commit = w.valid && !stall && !halted;

    assign reg_we      = commit && (wp.kind == K_REG);
    assign mem_we      = commit && (wp.kind == K_STORE);
    assign resteer     = commit && (wp.kind == K_BRANCH) && wp.mispredict;
    assign exc_valid   = commit && (wp.kind == K_EXC);
    assign halt_commit = commit && (wp.kind == K_HALT);

    // squash younger work on resteer, keep pipe empty once halted
    assign flush = resteer || halted;

    always_comb begin
        reg_wr.addr = wp.rd;
        reg_wr.data = wp.result;
        mem_wr.addr = wp.mem_addr;
        mem_wr.data = wp.mem_data;
    end

    assign resteer_pc = wp.redirect_pc;
    assign exc_code   = exc_valid ? wp.exc : EXC_NONE;

    always_ff @(posedge clk) begin
        if (rst) begin
            halted <= 1'b0;
        end else if (halt_commit) begin
            halted <= 1'b1;   // sticky until reset
        end
    end

    a_one_write: assert property (
        @(posedge clk) disable iff (rst)
        !(reg_we && mem_we)
    );

    // a resteer would drop a stalled store in the X/W register
    a_no_resteer_in_stall: assert property (
        @(posedge clk) disable iff (rst)
        !(resteer && stall)
    );

endmodule

`default_nettype wire

//--- uop_execute.sv
`timescale 1ns/1ns
`default_nettype none
`include "wb_defs.svh"

module uop_execute (
    pipe_if.dst x,
    pipe_if.src e
);

    import wb_pkg::*;

    localparam logic [`WB_XLEN-1:0] INSN_BYTES = 4;

    dec_t                dp;
    exe_t                res;
    logic [`WB_XLEN-1:0] sum;
    logic [`WB_XLEN-1:0] alu;
    logic                ovf;
    logic                taken;

    assign dp  = x.payload;
    assign sum = dp.opa + dp.opb;

    // signed overflow: same input signs, result sign flipped
    assign ovf = (dp.opa[`WB_XLEN-1] == dp.opb[`WB_XLEN-1]) &&
                 (sum[`WB_XLEN-1] != dp.opa[`WB_XLEN-1]);

    assign taken = (dp.op == OP_BEQ) ? (dp.opa == dp.opb) : (dp.opa != dp.opb);

    always_comb begin
        case (dp.op)
            OP_SUB:  alu = dp.opa - dp.opb;
            OP_AND:  alu = dp.opa & dp.opb;
            OP_OR:   alu = dp.opa | dp.opb;
            OP_XOR:  alu = dp.opa ^ dp.opb;
            OP_SHL:  alu = dp.opa << dp.opb[4:0];   // low 5 bits only
            default: alu = sum;
        endcase
    end

    always_comb begin
        res             = '0;
        res.kind        = K_REG;
        res.rd          = dp.rd;
        res.result      = alu;
        res.mem_addr    = dp.opa + dp.imm;
        res.mem_data    = dp.opb;
        res.redirect_pc = taken ? dp.pc + dp.imm : dp.pc + INSN_BYTES;
        res.exc         = EXC_NONE;
        if (dp.illegal) begin
            res.kind = K_EXC;
            res.exc  = EXC_ILLEGAL;
        end else begin
            case (dp.op)
                OP_ST: begin
                    res.kind = K_STORE;
                end
                OP_BEQ, OP_BNE: begin
                    res.kind       = K_BRANCH;
                    res.mispredict = taken != dp.pred_taken;
                end
                OP_HLT: begin
                    res.kind = K_HALT;
                end
                OP_ADD: begin
                    if (dp.trap_en && ovf) begin
                        res.kind = K_EXC;
                        res.exc  = EXC_OVERFLOW;
                    end
                end
                default: begin
                    res.kind = K_REG;
                end
            endcase
        end
    end

    assign e.valid   = x.valid;
    assign e.payload = res;

endmodule

`default_nettype wire

//--- uop_decode.sv
`timescale 1ns/1ns
`default_nettype none
`include "wb_defs.svh"

module uop_decode (
    input  wire logic                valid,
    input  wire logic [`WB_XLEN-1:0] word,
    input  wire logic [`WB_XLEN-1:0] pc,
    input  wire logic [`WB_XLEN-1:0] opa,
    input  wire logic [`WB_XLEN-1:0] opb,
    pipe_if.src                      d
);

    import wb_pkg::*;

    localparam int IMM_W = `WB_IMM_HI - `WB_IMM_LO + 1;

    logic [3:0]       opcode;
    logic             known;
    logic [IMM_W-1:0] imm_raw;
    dec_t             rec;

    assign opcode  = word[`WB_OP_HI:`WB_OP_LO];
    assign imm_raw = word[`WB_IMM_HI:`WB_IMM_LO];

    always_comb begin
        case (opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL: begin
                known = 1'b1;
            end
            OP_ST, OP_BEQ, OP_BNE, OP_HLT: begin
                known = 1'b1;
            end
            default: begin
                known = 1'b0;   // reserved encodings
            end
        endcase
    end

    always_comb begin
        rec            = '0;
        rec.op         = op_e'(opcode);
        rec.rd         = word[`WB_RD_HI:`WB_RD_LO];
        rec.pred_taken = word[`WB_PRED_BIT];
        rec.trap_en    = word[`WB_TRAP_BIT];
        rec.imm        = {{(`WB_XLEN-IMM_W){imm_raw[IMM_W-1]}}, imm_raw};
        rec.pc         = pc;
        rec.opa        = opa;
        rec.opb        = opb;
        rec.illegal    = !known;
    end

    // D/X register decides whether this gets in
    assign d.valid   = valid;
    assign d.payload = rec;

endmodule

`default_nettype wire

//--- pipe_reg.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire logic clk,
    input  wire logic rst,
    pipe_if.dst       up,
    pipe_if.src       down
);

    logic     valid_q;
    payload_t payload_q;

    always_ff @(posedge clk) begin
        if (rst || up.flush) begin
            valid_q <= 1'b0;
        end else if (!up.stall) begin
            valid_q <= up.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!up.stall) begin
            payload_q <= up.payload;
        end
    end

    assign down.valid   = valid_q;
    assign down.payload = payload_q;

    // a stalled item must stay valid and not change under the consumer
    a_hold_stable: assert property (
        @(posedge clk) disable iff (rst)
        (up.stall && valid_q) |=> (valid_q && $stable(payload_q))
    );

endmodule

`default_nettype wire

//--- pipe_if.sv
`timescale 1ns/1ns
`default_nettype none

interface pipe_if #(
    parameter type payload_t = logic
) ();

    logic     valid;
    logic     stall;    // hold everything in place
    logic     flush;    // drop the item on this edge
    payload_t payload;

    // producer side
    modport src (
        output valid,
        output payload,
        input  stall,
        input  flush
    );

    // consumer side
    modport dst (
        input valid,
        input payload,
        input stall,
        input flush
    );

    // stall and flush owner
    modport ctl (
        input  valid,
        output stall,
        output flush
    );

endinterface

`default_nettype wire

//--- wb_pkg.sv
`default_nettype none
`include "wb_defs.svh"

package wb_pkg;

    typedef enum logic [3:0] {
        OP_ADD = 4'd0, OP_SUB = 4'd1, OP_AND = 4'd2, OP_OR  = 4'd3, OP_XOR = 4'd4,
        OP_SHL = 4'd5, OP_ST  = 4'd6, OP_BEQ = 4'd7, OP_BNE = 4'd8, OP_HLT = 4'd9
    } op_e;  // 10..15 illegal

    typedef enum logic [3:0] {EXC_NONE = 4'd0, EXC_OVERFLOW = 4'd1, EXC_ILLEGAL = 4'd2} exc_e;

    // what writeback does with an item
    typedef enum logic [2:0] {K_REG, K_STORE, K_BRANCH, K_HALT, K_EXC} kind_e;

    typedef struct packed {
        op_e                 op;
        logic [`WB_RIDX-1:0] rd;
        logic                pred_taken;
        logic                trap_en;
        logic [`WB_XLEN-1:0] imm;         // sign extended
        logic [`WB_XLEN-1:0] pc;
        logic [`WB_XLEN-1:0] opa;
        logic [`WB_XLEN-1:0] opb;
        logic                illegal;
    } dec_t;

    typedef struct packed {
        kind_e               kind;
        logic [`WB_RIDX-1:0] rd;
        logic [`WB_XLEN-1:0] result;
        logic [`WB_XLEN-1:0] mem_addr;
        logic [`WB_XLEN-1:0] mem_data;
        logic                mispredict;
        logic [`WB_XLEN-1:0] redirect_pc;
        exc_e                exc;
    } exe_t;

    typedef struct packed {
        logic [`WB_RIDX-1:0] addr;
        logic [`WB_XLEN-1:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic [`WB_XLEN-1:0] addr;
        logic [`WB_XLEN-1:0] data;
    } mem_wr_t;

endpackage

`default_nettype wire

//--- wb_defs.svh
`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// datapath and register file geometry
`define WB_XLEN 32
`define WB_RIDX 3

// micro-op word layout
`define WB_OP_HI    31
`define WB_OP_LO    28
`define WB_RD_HI    27
`define WB_RD_LO    25
`define WB_PRED_BIT 24
`define WB_TRAP_BIT 23
`define WB_IMM_HI   15
`define WB_IMM_LO   0

`endif
